/* design/bf16_settings.svh */
`ifndef BF16_SETTINGS_SVH
`define BF16_SETTINGS_SVH

// bfloat16 word layout
// sign, 8 exponent bits, 7 stored mantissa bits
`define BF16_WIDTH 16
`define BF16_EXP_WIDTH 8
`define BF16_MANT_WIDTH 7

// significand with the hidden bit in front of the mantissa
`define BF16_FRAC_WIDTH 8

// exponent bias of the encoded exponent
`define BF16_BIAS 127

// first encoded exponent that no longer fits
`define BF16_MAX_ENC_EXP 255

// largest finite magnitude, used on overflow
`define BF16_SAT_ENC_EXP 8'd254
`define BF16_SAT_MANT 7'h7f

// quotient bits retired per long divider iteration
// radix 16
`define LONG_DIV_RADIX_BITS 4

`endif

/* design/bf16_pkg.sv */
`include "bf16_settings.svh"

package bf16_pkg;

	// encoded fields of one bfloat16 word
	typedef struct packed
	{
		logic sign;
		logic [`BF16_EXP_WIDTH-1:0] enc_exp;
		logic [`BF16_MANT_WIDTH-1:0] enc_mant;
	} bf16_fields_t;

	// raw view for the ports, field view for the arithmetic
	typedef union packed
	{
		logic [`BF16_WIDTH-1:0] raw;
		bf16_fields_t fields;
	} bf16_word_u;

	// operation select at the top level
	typedef enum logic
	{
		op_mul,
		op_div
	} bf16_op_e;

	// command into a multiply or divide unit
	typedef struct packed
	{
		logic start;
		bf16_word_u a;
		bf16_word_u b;
	} binop_in_t;

	// result out of a multiply or divide unit
	typedef struct packed
	{
		logic data_valid;
		logic can_accept_cmd;
		bf16_word_u data;
	} oper_out_t;

	// long divider command
	// dividend is 16 bits, divisor is one significand
	typedef struct packed
	{
		logic start;
		logic [`BF16_WIDTH-1:0] dividend;
		logic [`BF16_FRAC_WIDTH-1:0] divisor;
	} long_div_in_t;

	typedef struct packed
	{
		logic data_valid;
		logic can_accept_cmd;
		logic [`BF16_WIDTH-1:0] quotient;
	} long_div_out_t;

	// bfloat16 divider FSM
	typedef enum logic [1:0]
	{
		st_div_idle,
		st_div_wait_quot,
		st_div_normalize,
		st_div_finish
	} div_state_e;

	// long divider FSM
	typedef enum logic
	{
		st_ld_idle,
		st_ld_iterate
	} long_div_state_e;

endpackage

/* design/long_div_u16_by_u8.sv */
`include "bf16_settings.svh"

module long_div_u16_by_u8
(
	input logic clk,
	input logic reset,
	input bf16_pkg::long_div_in_t in,
	output bf16_pkg::long_div_out_t out
);

	bf16_pkg::long_div_state_e state;

	// dividend digits leave at the top, quotient digits enter at the bottom
	// after the last iteration this holds the whole quotient
	logic [`BF16_WIDTH-1:0] work;

	// partial remainder, always below the divisor
	logic [`BF16_FRAC_WIDTH-1:0] rem;
	logic [`BF16_FRAC_WIDTH-1:0] divisor;
	logic [1:0] iter_count;
	logic data_valid;
	logic can_accept_cmd;
	logic accept;

	// remainder shifted by one radix digit, plus trial multiples
	logic [`BF16_FRAC_WIDTH+`LONG_DIV_RADIX_BITS-1:0] div_ext;
	logic [`BF16_FRAC_WIDTH+`LONG_DIV_RADIX_BITS-1:0] shifted;
	logic [`BF16_FRAC_WIDTH+`LONG_DIV_RADIX_BITS-1:0] trial;
	logic [`BF16_FRAC_WIDTH+`LONG_DIV_RADIX_BITS-1:0] fit;
	logic [`BF16_FRAC_WIDTH+`LONG_DIV_RADIX_BITS-1:0] rem_next;
	logic [`LONG_DIV_RADIX_BITS-1:0] digit;

	assign accept = in.start && can_accept_cmd;

	assign out.data_valid = data_valid;
	assign out.can_accept_cmd = can_accept_cmd;
	assign out.quotient = work;

	assign div_ext = {{`LONG_DIV_RADIX_BITS{1'b0}}, divisor};

	// one radix-16 step
	// pick the largest multiple of the divisor not above shifted
	always_comb
	begin
		shifted = {rem, work[`BF16_WIDTH-1 -: `LONG_DIV_RADIX_BITS]};
		trial = '0;
		fit = '0;
		digit = '0;
		for (int i = 1; i < (1 << `LONG_DIV_RADIX_BITS); i++)
		begin
			// running sum gives i times the divisor
			trial = trial + div_ext;
			if (trial <= shifted)
			begin
				fit = trial;
				digit = i[`LONG_DIV_RADIX_BITS-1:0];
			end
		end
		// zero divisor fits every time, so the digit ends up all ones
		rem_next = shifted - fit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= bf16_pkg::st_ld_idle;
			iter_count <= '0;
			data_valid <= 1'b0;
			can_accept_cmd <= 1'b1;
			work <= '0;
		end
		else
		begin
			case (state)
			bf16_pkg::st_ld_idle:
			begin
				if (accept)
				begin
					state <= bf16_pkg::st_ld_iterate;
					work <= in.dividend;
					divisor <= in.divisor;
					rem <= '0;
					iter_count <= '0;
					data_valid <= 1'b0;
					can_accept_cmd <= 1'b0;
				end
			end

			bf16_pkg::st_ld_iterate:
			begin
				work <= {work[`BF16_WIDTH-`LONG_DIV_RADIX_BITS-1:0], digit};
				rem <= rem_next[`BF16_FRAC_WIDTH-1:0];
				iter_count <= iter_count + 2'd1;
				// four digits make the 16-bit quotient
				if (iter_count == 2'((`BF16_WIDTH / `LONG_DIV_RADIX_BITS) - 1))
				begin
					state <= bf16_pkg::st_ld_idle;
					data_valid <= 1'b1;
					can_accept_cmd <= 1'b1;
				end
			end
			endcase
		end
	end

	// no command may land in the middle of an iteration
	assert property (@(posedge clk) disable iff (reset)
		!(in.start && (state == bf16_pkg::st_ld_iterate)));

	// each step leaves a remainder below the divisor
	assert property (@(posedge clk) disable iff (reset)
		((state == bf16_pkg::st_ld_iterate) && (divisor != '0)) |-> (rem_next < div_ext));

endmodule

/* design/bf16_div.sv */
`include "bf16_settings.svh"

module bf16_div
(
	input logic clk,
	input logic reset,
	input bf16_pkg::binop_in_t in,
	output bf16_pkg::oper_out_t out
);

	bf16_pkg::div_state_e state;
	bf16_pkg::long_div_in_t ld_in;
	bf16_pkg::long_div_out_t ld_out;

	logic accept;

	// significands of the incoming operands
	logic [`BF16_FRAC_WIDTH-1:0] sig_a;
	logic [`BF16_FRAC_WIDTH-1:0] sig_b;

	// captured at accept
	logic [`BF16_FRAC_WIDTH-1:0] cap_sig_b;
	logic [`BF16_EXP_WIDTH-1:0] cap_exp_a;
	logic [`BF16_EXP_WIDTH-1:0] cap_exp_b;
	logic ret_sign;

	// working quotient and exponent
	logic [`BF16_WIDTH-1:0] ret_sig;
	logic signed [`BF16_WIDTH-1:0] ret_exp;
	logic signed [`BF16_WIDTH-1:0] exp_diff;

	logic data_valid;
	logic can_accept_cmd;
	bf16_pkg::bf16_word_u data;

	long_div_u16_by_u8 long_div
	(
		.clk(clk),
		.reset(reset),
		.in(ld_in),
		.out(ld_out)
	);

	assign accept = in.start && can_accept_cmd;

	// hidden bit only for a non-zero exponent
	assign sig_a = {|in.a.fields.enc_exp, in.a.fields.enc_mant};
	assign sig_b = {|in.b.fields.enc_exp, in.b.fields.enc_mant};

	// long divider starts on the same edge as the accept
	// dividend gets 8 fraction bits below the significand
	assign ld_in.start = accept;
	assign ld_in.dividend = {sig_a, {`BF16_FRAC_WIDTH{1'b0}}};
	assign ld_in.divisor = sig_b;

	// ea - eb + bias, wide and signed so both ends can be detected
	assign exp_diff = `BF16_WIDTH'(cap_exp_a) - `BF16_WIDTH'(cap_exp_b)
		+ `BF16_WIDTH'(`BF16_BIAS);

	assign out.data_valid = data_valid;
	assign out.can_accept_cmd = can_accept_cmd;
	assign out.data = data;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= bf16_pkg::st_div_idle;
			data_valid <= 1'b0;
			can_accept_cmd <= 1'b1;
			data <= '0;
		end
		else
		begin
			case (state)
			bf16_pkg::st_div_idle:
			begin
				if (accept)
				begin
					state <= bf16_pkg::st_div_wait_quot;
					cap_sig_b <= sig_b;
					cap_exp_a <= in.a.fields.enc_exp;
					cap_exp_b <= in.b.fields.enc_exp;
					ret_sign <= in.a.fields.sign ^ in.b.fields.sign;
					data_valid <= 1'b0;
					can_accept_cmd <= 1'b0;
				end
			end

			bf16_pkg::st_div_wait_quot:
			begin
				if (ld_out.data_valid)
				begin
					state <= bf16_pkg::st_div_normalize;
					// x / 0 gives a signed zero
					if (cap_sig_b == '0)
					begin
						ret_sig <= '0;
					end
					else
					begin
						ret_sig <= ld_out.quotient;
					end
					ret_exp <= exp_diff;
				end
			end

			bf16_pkg::st_div_normalize:
			begin
				state <= bf16_pkg::st_div_finish;
				// quotient of two 1.x values lies in 0.5 to 2
				if (ret_sig == '0)
				begin
					ret_exp <= '0;
				end
				else if (ret_sig[`BF16_FRAC_WIDTH])
				begin
					ret_sig <= ret_sig >> 1;
				end
				else
				begin
					ret_exp <= ret_exp - 1'b1;
				end
			end

			bf16_pkg::st_div_finish:
			begin
				state <= bf16_pkg::st_div_idle;
				data_valid <= 1'b1;
				can_accept_cmd <= 1'b1;
				data.fields.sign <= ret_sign;
				// underflow flushes, overflow saturates, truncating mantissa
				if (ret_exp[`BF16_WIDTH-1])
				begin
					data.fields.enc_exp <= '0;
					data.fields.enc_mant <= '0;
				end
				else if (ret_exp >= `BF16_MAX_ENC_EXP)
				begin
					data.fields.enc_exp <= `BF16_SAT_ENC_EXP;
					data.fields.enc_mant <= `BF16_SAT_MANT;
				end
				else
				begin
					data.fields.enc_exp <= ret_exp[`BF16_EXP_WIDTH-1:0];
					data.fields.enc_mant <= ret_sig[`BF16_MANT_WIDTH-1:0];
				end
			end
			endcase
		end
	end

	// quotient only turns valid while this FSM waits for it
	assert property (@(posedge clk) disable iff (reset)
		$rose(ld_out.data_valid) |-> (state == bf16_pkg::st_div_wait_quot));

	// long divider is always free when a divide is accepted
	assert property (@(posedge clk) disable iff (reset)
		accept |-> ld_out.can_accept_cmd);

endmodule

/* design/bf16_mul.sv */
`include "bf16_settings.svh"

module bf16_mul
(
	input logic clk,
	input logic reset,
	input bf16_pkg::binop_in_t in,
	output bf16_pkg::oper_out_t out
);

	logic accept;

	// one flag per pipeline step
	logic norm_pending;
	logic fin_pending;

	// captured operands
	logic ret_sign;
	logic [`BF16_FRAC_WIDTH-1:0] cap_sig_a;
	logic [`BF16_FRAC_WIDTH-1:0] cap_sig_b;
	logic [`BF16_EXP_WIDTH-1:0] cap_exp_a;
	logic [`BF16_EXP_WIDTH-1:0] cap_exp_b;

	// product of two 1.x significands, in 1 to 4
	logic [`BF16_WIDTH-1:0] product;
	logic signed [`BF16_WIDTH-1:0] exp_sum;

	logic [`BF16_MANT_WIDTH-1:0] ret_mant;
	logic signed [`BF16_WIDTH-1:0] ret_exp;

	logic data_valid;
	logic can_accept_cmd;
	bf16_pkg::bf16_word_u data;

	assign accept = in.start && can_accept_cmd;

	assign product = cap_sig_a * cap_sig_b;
	assign exp_sum = `BF16_WIDTH'(cap_exp_a) + `BF16_WIDTH'(cap_exp_b)
		- `BF16_WIDTH'(`BF16_BIAS);

	assign out.data_valid = data_valid;
	assign out.can_accept_cmd = can_accept_cmd;
	assign out.data = data;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			norm_pending <= 1'b0;
			fin_pending <= 1'b0;
			data_valid <= 1'b0;
			can_accept_cmd <= 1'b1;
			data <= '0;
		end
		else
		begin
			norm_pending <= accept;
			fin_pending <= norm_pending;
			if (accept)
			begin
				// hidden bit only for a non-zero exponent
				cap_sig_a <= {|in.a.fields.enc_exp, in.a.fields.enc_mant};
				cap_sig_b <= {|in.b.fields.enc_exp, in.b.fields.enc_mant};
				cap_exp_a <= in.a.fields.enc_exp;
				cap_exp_b <= in.b.fields.enc_exp;
				ret_sign <= in.a.fields.sign ^ in.b.fields.sign;
				data_valid <= 1'b0;
				can_accept_cmd <= 1'b0;
			end
			if (norm_pending)
			begin
				// zero product ends as a signed zero
				if (product == '0)
				begin
					ret_mant <= '0;
					ret_exp <= '0;
				end
				else if (product[`BF16_WIDTH-1])
				begin
					ret_mant <= product[`BF16_WIDTH-2 -: `BF16_MANT_WIDTH];
					ret_exp <= exp_sum + 1'b1;
				end
				else
				begin
					ret_mant <= product[`BF16_WIDTH-3 -: `BF16_MANT_WIDTH];
					ret_exp <= exp_sum;
				end
			end
			if (fin_pending)
			begin
				data_valid <= 1'b1;
				can_accept_cmd <= 1'b1;
				data.fields.sign <= ret_sign;
				// flush on underflow, saturate on overflow
				if (ret_exp[`BF16_WIDTH-1])
				begin
					data.fields.enc_exp <= '0;
					data.fields.enc_mant <= '0;
				end
				else if (ret_exp >= `BF16_MAX_ENC_EXP)
				begin
					data.fields.enc_exp <= `BF16_SAT_ENC_EXP;
					data.fields.enc_mant <= `BF16_SAT_MANT;
				end
				else
				begin
					data.fields.enc_exp <= ret_exp[`BF16_EXP_WIDTH-1:0];
					data.fields.enc_mant <= ret_mant;
				end
			end
		end
	end

	// two normal operands never leave the product below bit 14
	assert property (@(posedge clk) disable iff (reset)
		(norm_pending && (cap_exp_a != '0) && (cap_exp_b != '0))
		|-> (product[`BF16_WIDTH-1] || product[`BF16_WIDTH-2]));

endmodule

/* design/bf16_muldiv_unit.sv */
module bf16_muldiv_unit
(
	input logic clk,
	input logic reset,
	input logic start,
	input bf16_pkg::bf16_op_e op,
	input bf16_pkg::bf16_word_u a,
	input bf16_pkg::bf16_word_u b,
	output logic data_valid,
	output logic can_accept_cmd,
	output bf16_pkg::bf16_word_u result
);

	bf16_pkg::binop_in_t mul_in;
	bf16_pkg::binop_in_t div_in;
	bf16_pkg::oper_out_t mul_out;
	bf16_pkg::oper_out_t div_out;

	logic accept;

	// op of the last accepted command, selects the output
	bf16_pkg::bf16_op_e op_q;

	bf16_mul mul
	(
		.clk(clk),
		.reset(reset),
		.in(mul_in),
		.out(mul_out)
	);

	bf16_div div
	(
		.clk(clk),
		.reset(reset),
		.in(div_in),
		.out(div_out)
	);

	// new command only when neither unit is busy
	assign can_accept_cmd = mul_out.can_accept_cmd && div_out.can_accept_cmd;
	assign accept = start && can_accept_cmd;

	// start goes only to the selected unit
	assign mul_in.start = accept && (op == bf16_pkg::op_mul);
	assign mul_in.a = a;
	assign mul_in.b = b;
	assign div_in.start = accept && (op == bf16_pkg::op_div);
	assign div_in.a = a;
	assign div_in.b = b;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			op_q <= bf16_pkg::op_mul;
		end
		else if (accept)
		begin
			op_q <= op;
		end
	end

	// no registers here, latency is that of the selected unit
	always_comb
	begin
		if (op_q == bf16_pkg::op_div)
		begin
			data_valid = div_out.data_valid;
			result = div_out.data;
		end
		else
		begin
			data_valid = mul_out.data_valid;
			result = mul_out.data;
		end
	end

	// every accepted command makes the selected unit busy on the next cycle
	assert property (@(posedge clk) disable iff (reset)
		accept |=> !can_accept_cmd);

endmodule

/* dv/tb_bf16_muldiv.sv */
`include "bf16_settings.svh"

module tb_bf16_muldiv;
	timeunit 1ns;
	timeprecision 1ps;

	// 200 operations of at most 12 cycles, plus reset
	localparam int TIMEOUT_CYCLES = 200 * 12 + 20;

	logic clk;
	logic reset;
	logic start;
	bf16_pkg::bf16_op_e op;
	bf16_pkg::bf16_word_u a;
	bf16_pkg::bf16_word_u b;
	logic data_valid;
	logic can_accept_cmd;
	bf16_pkg::bf16_word_u result;

	int cycle_count = 0;
	int error_count = 0;
	integer seed;

	bf16_muldiv_unit uut
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.data_valid(data_valid),
		.can_accept_cmd(can_accept_cmd),
		.result(result)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// watchdog
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the DUT did not finish the tests in %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "watchdog expired");
		end
	end

	// hidden bit only when the exponent is non-zero
	function automatic int significand(input logic [15:0] w);
		if (w[14:7] != 8'd0)
			return (1 << `BF16_MANT_WIDTH) + int'(w[6:0]);
		return int'(w[6:0]);
	endfunction

	// flush below zero, saturate at the top, else plain fields
	function automatic logic [15:0] pack_word(input logic sign, input int exp_val, input int mant);
		if (exp_val < 0)
			return {sign, 15'd0};
		if (exp_val >= `BF16_MAX_ENC_EXP)
			return {sign, 8'd254, 7'h7f};
		return {sign, 8'(exp_val), 7'(mant)};
	endfunction

	function automatic logic [15:0] model_mul(input logic [15:0] x, input logic [15:0] y);
		logic sign;
		int prod;
		int exp_val;
		int mant;
		sign = x[15] ^ y[15];
		prod = significand(x) * significand(y);
		exp_val = int'(x[14:7]) + int'(y[14:7]) - `BF16_BIAS;
		if (prod == 0)
			return {sign, 15'd0};
		// product at or above 2.0 needs one more exponent step
		if (prod >= 32768)
		begin
			mant = (prod >> 8) % 128;
			exp_val = exp_val + 1;
		end
		else
			mant = (prod >> 7) % 128;
		return pack_word(sign, exp_val, mant);
	endfunction

	function automatic logic [15:0] model_div(input logic [15:0] x, input logic [15:0] y);
		logic sign;
		int quot;
		int exp_val;
		sign = x[15] ^ y[15];
		// divide by zero ends as zero quotient
		if (significand(y) == 0)
			quot = 0;
		else
			quot = (significand(x) * 256) / significand(y);
		exp_val = int'(x[14:7]) - int'(y[14:7]) + `BF16_BIAS;
		if (quot == 0)
			exp_val = 0;
		else if ((quot / 256) % 2 == 1)
			quot = quot / 2;
		else
			exp_val = exp_val - 1;
		return pack_word(sign, exp_val, quot % 128);
	endfunction

	function automatic logic [15:0] model_result(input bf16_pkg::bf16_op_e op_sel,
		input logic [15:0] x, input logic [15:0] y);
		if (op_sel == bf16_pkg::op_div)
			return model_div(x, y);
		return model_mul(x, y);
	endfunction

	task automatic check_equal(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// called and left on a falling edge
	task automatic issue_command(input bf16_pkg::bf16_op_e op_sel, input logic [15:0] x,
		input logic [15:0] y);
		while (!can_accept_cmd)
			@(negedge clk);
		start = 1'b1;
		op = op_sel;
		a.raw = x;
		b.raw = y;
		// accept edge
		@(posedge clk);
		@(negedge clk);
		start = 1'b0;
	endtask

	// counts rising edges after the accept edge until data_valid
	task automatic wait_result(input string name, output int cycles);
		cycles = 0;
		while (!data_valid)
		begin
			check_equal({name, " busy"}, 16'd0, 16'(can_accept_cmd));
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		check_equal({name, " ready"}, 16'd1, 16'(can_accept_cmd));
	endtask

	task automatic run_op(input string name, input bf16_pkg::bf16_op_e op_sel,
		input logic [15:0] x, input logic [15:0] y, output logic [15:0] res, output int cycles);
		issue_command(op_sel, x, y);
		wait_result(name, cycles);
		res = result.raw;
	endtask

	task automatic check_op(input string name, input bf16_pkg::bf16_op_e op_sel,
		input logic [15:0] x, input logic [15:0] y, input logic [15:0] expected);
		logic [15:0] res;
		int cycles;
		run_op(name, op_sel, x, y, res, cycles);
		check_equal(name, expected, res);
	endtask

	task automatic test_reset_state();
		check_equal("reset data_valid", 16'd0, 16'(data_valid));
		check_equal("reset can_accept_cmd", 16'd1, 16'(can_accept_cmd));
		check_equal("reset result", 16'd0, result.raw);
	endtask

	task automatic test_basic_mul_div();
		check_op("mul 3x2", bf16_pkg::op_mul, 16'h4040, 16'h4000, 16'h40c0);
		check_op("mul 1.5x1.5", bf16_pkg::op_mul, 16'h3fc0, 16'h3fc0, 16'h4010);
		check_op("mul -2x1.5", bf16_pkg::op_mul, 16'hc000, 16'h3fc0, 16'hc040);
		check_op("div 6/2", bf16_pkg::op_div, 16'h40c0, 16'h4000, 16'h4040);
		// 1/3 truncated
		check_op("div 1/3", bf16_pkg::op_div, 16'h3f80, 16'h4040, 16'h3eaa);
		check_op("div -6/-2", bf16_pkg::op_div, 16'hc0c0, 16'hc000, 16'h4040);
		check_op("div 1.5/-3", bf16_pkg::op_div, 16'h3fc0, 16'hc040,
			model_div(16'h3fc0, 16'hc040));
	endtask

	task automatic test_special_values();
		check_op("mul zero", bf16_pkg::op_mul, 16'h0000, 16'h4040, 16'h0000);
		check_op("mul neg zero", bf16_pkg::op_mul, 16'h8000, 16'h4040, 16'h8000);
		check_op("div zero dividend", bf16_pkg::op_div, 16'h0000, 16'h4000, 16'h0000);
		check_op("div neg zero divisor", bf16_pkg::op_div, 16'h4040, 16'h8000, 16'h8000);
		check_op("div by zero", bf16_pkg::op_div, 16'hc040, 16'h0000, 16'h8000);
		// largest exponents saturate
		check_op("mul overflow", bf16_pkg::op_mul, 16'h7f00, 16'h7f00, 16'h7f7f);
		check_op("div overflow", bf16_pkg::op_div, 16'hff00, 16'h0080, 16'hff7f);
		// smallest exponents flush
		check_op("mul underflow", bf16_pkg::op_mul, 16'h0080, 16'h0080, 16'h0000);
		check_op("mul neg underflow", bf16_pkg::op_mul, 16'h8080, 16'h0080, 16'h8000);
		check_op("div underflow", bf16_pkg::op_div, 16'h0080, 16'h7f00, 16'h0000);
	endtask

	task automatic test_latency();
		logic [15:0] res;
		int cycles;
		run_op("latency mul", bf16_pkg::op_mul, 16'h3fc0, 16'h4040, res, cycles);
		check_equal("latency mul cycles", 16'd2, 16'(cycles));
		check_equal("latency mul", model_mul(16'h3fc0, 16'h4040), res);
		run_op("latency div", bf16_pkg::op_div, 16'h3fc0, 16'h4040, res, cycles);
		check_equal("latency div cycles", 16'd7, 16'(cycles));
		check_equal("latency div", model_div(16'h3fc0, 16'h4040), res);
	endtask

	task automatic test_ignored_start();
		int cycles;
		// 3 / 1.5 is in flight
		issue_command(bf16_pkg::op_div, 16'h4040, 16'h3fc0);
		@(negedge clk);
		// overflowing multiply while busy
		start = 1'b1;
		op = bf16_pkg::op_mul;
		a.raw = 16'h7f00;
		b.raw = 16'h7f00;
		@(negedge clk);
		start = 1'b0;
		wait_result("ignored start", cycles);
		check_equal("ignored start", 16'h4000, result.raw);
	endtask

	task automatic test_random();
		logic [15:0] x;
		logic [15:0] y;
		logic sel_bit;
		bf16_pkg::bf16_op_e op_sel;
		for (int i = 0; i < 150; i++)
		begin
			x = 16'($random(seed));
			y = 16'($random(seed));
			sel_bit = 1'($random(seed));
			// every other pair kept near the bias so most results stay normal
			if (i % 2 == 0)
			begin
				x[14:11] = 4'h7;
				y[14:11] = 4'h8;
			end
			op_sel = sel_bit ? bf16_pkg::op_div : bf16_pkg::op_mul;
			check_op($sformatf("random %0d", i), op_sel, x, y, model_result(op_sel, x, y));
		end
	endtask

	initial
	begin
		seed = 1685;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		op = bf16_pkg::op_mul;
		a = '0;
		b = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_basic_mul_div();
		test_special_values();
		test_latency();
		test_ignored_start();
		test_random();
		if (error_count == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* bf16_muldiv.f */
+incdir+design
design/bf16_pkg.sv
design/long_div_u16_by_u8.sv
design/bf16_div.sv
design/bf16_mul.sv
design/bf16_muldiv_unit.sv
dv/tb_bf16_muldiv.sv

/* Bender.yml */
package:
  name: bf16_muldiv

export_include_dirs:
  - design

sources:
  - design/bf16_pkg.sv
  - design/long_div_u16_by_u8.sv
  - design/bf16_div.sv
  - design/bf16_mul.sv
  - design/bf16_muldiv_unit.sv
  - target: test
    files:
      - dv/tb_bf16_muldiv.sv
